// File: project.f
+incdir+design
+incdir+test
design/cpu_pkg.sv
design/bypass_if.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/hazard_unit.sv
design/cpu_core.sv
test/tb_cpu.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_cpu -f project.f \
    && ./obj_dir/Vtb_cpu > sim.log 2>&1 \
    || echo "verilator build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q 'All tests passed!' sim.log 2>/dev/null && echo "simulation passed" && exit 0
echo "simulation failed, see sim.log"
exit 1

// File: test/cpu_tests.svh
// directed tests and their program images, included inside the tb_cpu module
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// fields from the top: rs2 or imm, rs1, rd, opcode
function automatic word_t encode(opcode_t op, int f_rd, int f_rs1, int f_hi);
    return {4'(f_hi), 4'(f_rs1), 4'(f_rd), op};
endfunction

// byte immediate fills bits 15:8
function automatic word_t encode_li(int rd, int imm8);
    return {8'(imm8), 4'(rd), op_li};
endfunction

task automatic alu_ops();
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t a;
    word_t b;
    // 0xed sign-extends, so b is negative
    a = 16'h005a;
    b = 16'hffed;
    prog.push_back(encode_li(1, 'h5a));
    prog.push_back(encode_li(2, 'hed));
    prog.push_back(encode_li(15, 'h20));
    prog.push_back(encode(op_add, 3, 1, 2));
    prog.push_back(encode(op_sub, 4, 1, 2));
    prog.push_back(encode(op_and, 5, 1, 2));
    prog.push_back(encode(op_or, 6, 1, 2));
    prog.push_back(encode(op_addi, 7, 1, -3));
    prog.push_back(encode(op_sw, 3, 15, 0));
    prog.push_back(encode(op_sw, 4, 15, 1));
    prog.push_back(encode(op_sw, 5, 15, 2));
    prog.push_back(encode(op_sw, 6, 15, 3));
    prog.push_back(encode(op_sw, 7, 15, 4));
    prog.push_back(encode_li(14, 'h7f));
    prog.push_back(encode(op_sw, 0, 14, 0));
    exp_addr.push_back(16'h0020);
    exp_data.push_back(a + b);
    exp_addr.push_back(16'h0021);
    exp_data.push_back(a - b);
    exp_addr.push_back(16'h0022);
    exp_data.push_back(a & b);
    exp_addr.push_back(16'h0023);
    exp_data.push_back(a | b);
    exp_addr.push_back(16'h0024);
    exp_data.push_back(a - 16'd3);
    load_and_reset(prog);
    run_to_marker();
    compare_stores("alu_ops", exp_addr, exp_data);
endtask

task automatic forwarding_chain();
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t v [8];
    v[1] = 16'h0011;
    v[2] = v[1] + 16'd5;
    v[3] = v[2] + v[1];
    v[4] = v[3] - 16'd7;
    v[5] = v[4] + v[3];
    v[6] = v[5] + v[5];
    v[7] = v[6] + 16'd1;
    prog.push_back(encode_li(15, 'h30));
    prog.push_back(encode_li(1, 'h11));
    prog.push_back(encode(op_addi, 2, 1, 5));
    prog.push_back(encode(op_add, 3, 2, 1));
    prog.push_back(encode(op_addi, 4, 3, -7));
    prog.push_back(encode(op_add, 5, 4, 3));
    prog.push_back(encode(op_add, 6, 5, 5));
    // store data straight from the memory stage
    prog.push_back(encode(op_sw, 6, 15, 1));
    prog.push_back(encode(op_addi, 7, 6, 1));
    prog.push_back(encode(op_sw, 7, 15, 0));
    prog.push_back(encode_li(14, 'h7f));
    prog.push_back(encode(op_sw, 0, 14, 0));
    exp_addr.push_back(16'h0031);
    exp_data.push_back(v[6]);
    exp_addr.push_back(16'h0030);
    exp_data.push_back(v[7]);
    load_and_reset(prog);
    run_to_marker();
    compare_stores("forwarding", exp_addr, exp_data);
endtask

task automatic load_use_stall();
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t sum;
    prog.push_back(encode_li(15, 'h40));
    prog.push_back(encode(op_lw, 1, 15, 3));
    prog.push_back(encode(op_lw, 2, 15, -2));
    prog.push_back(encode(op_add, 3, 1, 2));
    prog.push_back(encode(op_lw, 4, 15, 7));
    prog.push_back(encode(op_add, 5, 4, 3));
    prog.push_back(encode(op_sw, 3, 15, 0));
    prog.push_back(encode(op_sw, 5, 15, 1));
    prog.push_back(encode_li(14, 'h7f));
    prog.push_back(encode(op_sw, 0, 14, 0));
    load_and_reset(prog);
    run_to_marker();
    // loaded words are never overwritten by this program
    sum = dmem[8'h43] + dmem[8'h3e];
    exp_addr.push_back(16'h0040);
    exp_data.push_back(sum);
    exp_addr.push_back(16'h0041);
    exp_data.push_back(dmem[8'h47] + sum);
    check_value("load_use load count", 3, ld_addr.size());
    check_value("load_use load address", 'h43, int'(ld_addr[0]));
    check_value("load_use load address", 'h3e, int'(ld_addr[1]));
    check_value("load_use load address", 'h47, int'(ld_addr[2]));
    compare_stores("load_use", exp_addr, exp_data);
endtask

task automatic branch_flush();
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    prog.push_back(encode_li(15, 'h50));
    prog.push_back(encode_li(1, 'h09));
    prog.push_back(encode_li(2, 'h09));
    prog.push_back(encode_li(13, 'h60));
    // taken, lands on word 7
    prog.push_back(encode(op_beq, 1, 2, 3));
    prog.push_back(encode(op_sw, 1, 13, 0));
    prog.push_back(encode(op_sw, 2, 13, 1));
    prog.push_back(encode(op_sw, 1, 15, 0));
    prog.push_back(encode_li(3, 'h05));
    // not taken, would skip to the marker
    prog.push_back(encode(op_beq, 3, 1, 3));
    prog.push_back(encode(op_sw, 3, 15, 1));
    prog.push_back(encode_li(14, 'h7f));
    prog.push_back(encode(op_sw, 0, 14, 0));
    exp_addr.push_back(16'h0050);
    exp_data.push_back(16'h0009);
    exp_addr.push_back(16'h0051);
    exp_data.push_back(16'h0005);
    load_and_reset(prog);
    run_to_marker();
    foreach (st_addr[i]) begin
        assert (st_addr[i] != 16'h0060 && st_addr[i] != 16'h0061) else begin
            $display("branches: a flushed store reached address %h", st_addr[i]);
            abort_run();
        end
    end
    compare_stores("branches", exp_addr, exp_data);
endtask

task automatic zero_register();
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    prog.push_back(encode_li(0, 'h33));
    prog.push_back(encode(op_addi, 0, 0, 5));
    prog.push_back(encode(op_addi, 1, 0, 2));
    prog.push_back(encode_li(15, 'h70));
    prog.push_back(encode(op_sw, 0, 15, 0));
    prog.push_back(encode(op_sw, 1, 15, 1));
    prog.push_back(encode_li(14, 'h7f));
    prog.push_back(encode(op_sw, 0, 14, 0));
    exp_addr.push_back(16'h0070);
    exp_data.push_back(16'h0000);
    exp_addr.push_back(16'h0071);
    exp_data.push_back(16'h0002);
    load_and_reset(prog);
    run_to_marker();
    compare_stores("r0", exp_addr, exp_data);
endtask

`endif

// File: test/tb_cpu.sv
// testbench top for the pipelined core, runs the directed tests from cpu_tests.svh
`include "cpu_settings.svh"

module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    reset_cycles = 16;
    localparam int    dmem_words   = 256;
    localparam int    pad_words    = 4;
    localparam word_t marker_addr  = 16'h007f;

    logic  clock;
    logic  arst_n;
    logic  prog_we;
    pc_t   prog_addr;
    word_t prog_data;
    word_t read_in;
    word_t mem_addr;
    logic  mem_read;
    logic  mem_write;
    word_t write_out;

    // data memory model and what the monitor saw
    word_t       dmem [dmem_words];
    word_t       fill_word;
    logic [15:0] lfsr_state  = 16'd82;
    logic        mem_filled  = 1'b0;
    logic        marker_seen = 1'b0;
    word_t       st_addr [$];
    word_t       st_data [$];
    word_t       ld_addr [$];
    int          cycles      = 0;
    int          cycle_limit = reset_cycles;

    cpu_core dut0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .read_in   (read_in),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .write_out (write_out)
    );

    always begin
        clock = 1'b0;
        #2;
        clock = 1'b1;
        #2;
    end

    // same-cycle read, 256 words so only the low address byte decodes
    assign read_in = dmem[mem_addr[7:0]];

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(string what, int expected, int actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
            abort_run();
        end
    endtask

    // sampled mid-cycle, memory stage outputs are settled by then
    always @(negedge clock) begin
        if (!arst_n) begin
            st_addr.delete();
            st_data.delete();
            ld_addr.delete();
            marker_seen = 1'b0;
            if (!mem_filled) begin
                for (int i = 0; i < dmem_words; i++) begin
                    for (int b = 0; b < `CPU_XLEN; b++) begin
                        fill_word  = {fill_word[`CPU_XLEN-2:0], lfsr_state[0]};
                        lfsr_state = lfsr_step(lfsr_state);
                    end
                    dmem[i[7:0]] = fill_word;
                end
                mem_filled = 1'b1;
            end
        end else begin
            mem_filled = 1'b0;
            if (mem_read) begin
                ld_addr.push_back(mem_addr);
            end
            if (mem_write) begin
                if (mem_addr == marker_addr) begin
                    marker_seen = 1'b1;
                end else begin
                    st_addr.push_back(mem_addr);
                    st_data.push_back(write_out);
                end
                dmem[mem_addr[7:0]] = write_out;
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no marker store after %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // reset is held while the program goes in, at least reset_cycles long
    task automatic load_and_reset(word_t prog[$]);
        int words;
        int hold;
        words = prog.size() + pad_words;
        hold = (words > reset_cycles) ? words : reset_cycles;
        cycle_limit = cycle_limit + 3 * prog.size() + hold;
        @(posedge clock);
        #0.5;
        arst_n = 1'b0;
        for (int i = 0; i < hold; i++) begin
            // trailing nops keep the fetch past the marker store defined
            prog_we   = (i < words);
            prog_addr = pc_t'(i);
            prog_data = (i < prog.size()) ? prog[i] : '0;
            @(posedge clock);
            #0.5;
        end
        prog_we = 1'b0;
        arst_n  = 1'b1;
    endtask

    task automatic run_to_marker();
        while (!marker_seen) begin
            @(posedge clock);
        end
    endtask

    task automatic compare_stores(string name, word_t exp_addr[$], word_t exp_data[$]);
        check_value({name, " store count"}, exp_addr.size(), st_addr.size());
        foreach (exp_addr[i]) begin
            check_value({name, " store address"}, int'(exp_addr[i]), int'(st_addr[i]));
            check_value({name, " store data"}, int'(exp_data[i]), int'(st_data[i]));
        end
    endtask

    `include "cpu_tests.svh"

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        alu_ops();
        forwarding_chain();
        load_use_stall();
        branch_flush();
        zero_register();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: design/cpu_core.sv
// top level of the five-stage core; data memory attaches to the plain memory ports
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    prog_we,
    input  logic [`CPU_IMEM_AW-1:0] prog_addr,
    input  logic [`CPU_XLEN-1:0]    prog_data,
    input  logic [`CPU_XLEN-1:0]    read_in,
    output logic [`CPU_XLEN-1:0]    mem_addr,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic [`CPU_XLEN-1:0]    write_out
);

    fd_t        fd_d;
    fd_t        fd_q;
    de_t        de_d;
    de_t        de_q;
    em_t        em_d;
    em_t        em_q;
    mw_t        mw_d;
    mw_t        mw_q;
    logic       stall;
    logic       flush;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    logic       branch_taken;
    pc_t        branch_target;

    bypass_if byp0 ();

    fetch_stage fetch0 (
        .clock         (clock),
        .arst_n        (arst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .fd            (fd_d)
    );

    pipe_reg #(.payload_t(fd_t)) fd_reg0 (
        .clock (clock), .arst_n (arst_n),
        .stall (stall), .flush (flush), .bubble (1'b0),
        .d     (fd_d),  .q     (fd_q)
    );

    decode_stage decode0 (
        .clock  (clock),
        .arst_n (arst_n),
        .fd     (fd_q),
        .wb     (mw_q),
        .byp    (byp0),
        .de     (de_d)
    );

    // a stalled decode leaves a bubble in execute
    pipe_reg #(.payload_t(de_t)) de_reg0 (
        .clock (clock), .arst_n (arst_n),
        .stall (1'b0),  .flush (flush), .bubble (stall),
        .d     (de_d),  .q     (de_q)
    );

    execute_stage execute0 (
        .de            (de_q),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (em_q.alu_result),
        .wb_result     (wb_value(mw_q)),
        .em            (em_d),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    pipe_reg #(.payload_t(em_t)) em_reg0 (
        .clock (clock), .arst_n (arst_n),
        .stall (1'b0),  .flush (1'b0), .bubble (1'b0),
        .d     (em_d),  .q     (em_q)
    );

    // memory stage, load data comes back in the same cycle
    assign mem_addr  = em_q.alu_result;
    assign mem_read  = em_q.ctrl.mem_read;
    assign mem_write = em_q.ctrl.mem_write;
    assign write_out = em_q.store_data;

    assign mw_d.reg_write  = em_q.ctrl.reg_write;
    assign mw_d.mem_read   = em_q.ctrl.mem_read;
    assign mw_d.alu_result = em_q.alu_result;
    assign mw_d.load_data  = read_in;
    assign mw_d.rd         = em_q.rd;

    pipe_reg #(.payload_t(mw_t)) mw_reg0 (
        .clock (clock), .arst_n (arst_n),
        .stall (1'b0),  .flush (1'b0), .bubble (1'b0),
        .d     (mw_d),  .q     (mw_q)
    );

    // pipeline register fields seen by the hazard unit
    assign byp0.ex_rs1  = de_q.rs1;
    assign byp0.ex_rs2  = de_q.rs2;
    assign byp0.ex_rd   = de_q.rd;
    assign byp0.ex_we   = de_q.ctrl.reg_write;
    assign byp0.ex_load = de_q.ctrl.mem_read;
    assign byp0.mem_rd  = em_q.rd;
    assign byp0.mem_we  = em_q.ctrl.reg_write;
    assign byp0.wb_rd   = mw_q.rd;
    assign byp0.wb_we   = mw_q.reg_write;

    hazard_unit hazard0 (
        .byp          (byp0),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

endmodule

// File: design/hazard_unit.sv
// load-use stall, branch flush and operand forwarding selects for the pipeline
module hazard_unit import cpu_pkg::*; (
    bypass_if.hazard   byp,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    logic load_use;

    // youngest producer wins and r0 is never forwarded
    function automatic logic [1:0] fwd_sel(reg_idx_t rs);
        if (rs == '0) begin
            return fwd_reg;
        end
        if (byp.mem_we && byp.mem_rd == rs) begin
            return fwd_mem;
        end
        if (byp.wb_we && byp.wb_rd == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    // unused decode sources are zero and r0 never stalls
    assign load_use = byp.ex_load && byp.ex_we && byp.ex_rd != '0 &&
                      (byp.ex_rd == byp.dec_rs1 || byp.ex_rd == byp.dec_rs2);

    // flush beats stall
    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

    assign fwd_a = fwd_sel(byp.ex_rs1);
    assign fwd_b = fwd_sel(byp.ex_rs2);

    // a load in execute always reports its register write
    always_comb begin
        assert final (!byp.ex_load || byp.ex_we)
            else $error("load in execute without a register write");
    end

endmodule

// File: design/execute_stage.sv
// execute stage with operand forwarding, the alu and beq resolution
module execute_stage import cpu_pkg::*; (
    input  de_t        de,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  word_t      mem_result,
    input  word_t      wb_result,
    output em_t        em,
    output logic       branch_taken,
    output pc_t        branch_target
);

    word_t op_a;
    word_t op_b_reg;
    word_t alu_b;
    word_t store_fwd;
    word_t alu_y;

    function automatic word_t pick(logic [1:0] sel, word_t reg_val);
        case (sel)
            fwd_mem: return mem_result;
            fwd_wb:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    // store data shares the rs2 select
    assign op_a      = pick(fwd_a, de.a);
    assign op_b_reg  = pick(fwd_b, de.b);
    assign store_fwd = pick(fwd_b, de.store_data);
    assign alu_b     = de.ctrl.use_imm ? de.imm : op_b_reg;

    always_comb begin
        case (de.ctrl.alu_op)
            alu_sub:    alu_y = op_a - alu_b;
            alu_and:    alu_y = op_a & alu_b;
            alu_or:     alu_y = op_a | alu_b;
            alu_pass_b: alu_y = alu_b;
            default:    alu_y = op_a + alu_b;
        endcase
    end

    // target is relative to the branch's own pc
    assign branch_taken  = de.ctrl.is_branch && (op_a == op_b_reg);
    assign branch_target = de.pc + de.imm[$bits(pc_t)-1:0];

    assign em.ctrl       = de.ctrl;
    assign em.alu_result = alu_y;
    assign em.store_data = store_fwd;
    assign em.rd         = de.rd;

    // a redirect only ever comes from a side-effect-free beq out of decode
    always_comb begin
        assert final (!branch_taken || (!de.ctrl.reg_write && !de.ctrl.mem_read
                      && !de.ctrl.mem_write))
            else $error("taken branch carries a register or memory write");
    end

endmodule

// File: design/decode_stage.sv
// instruction decode, immediate generation and the register file with write-through
`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  fd_t      fd,
    input  mw_t      wb,
    bypass_if.decode byp,
    output de_t      de
);

    word_t    regs [`CPU_NREGS];
    word_t    wb_data;
    opcode_t  op;
    ctrl_t    ctrl;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;

    assign wb_data = wb_value(wb);

    // r0 is hardwired, a same-cycle write is passed straight through
    function automatic word_t rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        op   = opcode_t'(fd.instr[3:0]);
        ctrl = '0;
        rd   = fd.instr[7:4];
        rs1  = '0;
        rs2  = '0;
        imm  = {{(`CPU_XLEN-4){fd.instr[15]}}, fd.instr[15:12]};
        case (op)
            op_add, op_sub, op_and, op_or: begin
                ctrl.reg_write = 1'b1;
                rs1 = fd.instr[11:8];
                rs2 = fd.instr[15:12];
                case (op)
                    op_sub:  ctrl.alu_op = alu_sub;
                    op_and:  ctrl.alu_op = alu_and;
                    op_or:   ctrl.alu_op = alu_or;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_addi: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1 = fd.instr[11:8];
            end
            op_li: begin
                // byte immediate overlaps the rs1 field
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{(`CPU_XLEN-8){fd.instr[15]}}, fd.instr[15:8]};
            end
            op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                rs1 = fd.instr[11:8];
            end
            op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                rs1 = fd.instr[11:8];
                rs2 = fd.instr[7:4];
            end
            op_beq: begin
                ctrl.is_branch = 1'b1;
                rs1 = fd.instr[11:8];
                rs2 = fd.instr[7:4];
            end
            default: begin
                // unused encodings behave as nop
                rd = '0;
            end
        endcase
    end

    // register file in flops, cleared on reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb_data;
        end
    end

    always_comb begin
        de.ctrl       = ctrl;
        de.pc         = fd.pc;
        de.a          = rf_read(rs1);
        de.b          = rf_read(rs2);
        de.store_data = ctrl.mem_write ? rf_read(rs2) : '0;
        de.imm        = imm;
        de.rd         = rd;
        de.rs1        = rs1;
        de.rs2        = rs2;
    end

    assign byp.dec_rs1 = rs1;
    assign byp.dec_rs2 = rs2;

endmodule

// File: design/fetch_stage.sv
// instruction fetch: pc, private instruction memory with its load port, next-pc select
`include "cpu_settings.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  branch_taken,
    input  pc_t   branch_target,
    input  logic  prog_we,
    input  pc_t   prog_addr,
    input  word_t prog_data,
    output fd_t   fd
);

    word_t imem [`CPU_IMEM_DEPTH];
    pc_t   pc;
    pc_t   pc_next;

    // loaded by the program port while reset is held
    always_ff @(posedge clock) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // taken branch wins over a load-use hold
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign fd.pc    = pc;
    assign fd.instr = imem[pc];

    // no program writes once the core has started running
    assert property (@(posedge clock) disable iff (!arst_n) !(prog_we && pc != '0))
        else $error("program port written while the core is running");

endmodule

// File: design/pipe_reg.sv
// stage boundary register for any packed payload, with hold, flush and bubble insertion
module pipe_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload carries a nop control word
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush || bubble) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // upstream stages must never hand over undefined payloads
    assert property (@(posedge clock) disable iff (!arst_n) !$isunknown(q))
        else $error("pipe_reg holds an unknown payload");

endmodule

// File: design/bypass_if.sv
// register numbers and write enables gathered from the pipeline for hazard detection
interface bypass_if import cpu_pkg::*; ();

    // effective sources of the instruction in decode, zero when unused
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;

    // instruction in execute
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    reg_idx_t ex_rd;
    logic     ex_we;
    logic     ex_load;

    // older instructions still able to forward
    reg_idx_t mem_rd;
    logic     mem_we;
    reg_idx_t wb_rd;
    logic     wb_we;

    modport decode (
        output dec_rs1, dec_rs2
    );

    modport pipe (
        output ex_rs1, ex_rs2, ex_rd, ex_we, ex_load,
        output mem_rd, mem_we, wb_rd, wb_we
    );

    modport hazard (
        input dec_rs1, dec_rs2,
        input ex_rs1, ex_rs2, ex_rd, ex_we, ex_load,
        input mem_rd, mem_we, wb_rd, wb_we
    );

endinterface

// File: design/cpu_pkg.sv
// shared types of the pipelined core: opcodes, alu ops, control word and stage payloads
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]           word_t;
    typedef logic [`CPU_IMEM_AW-1:0]        pc_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0]  reg_idx_t;

    // opcode lives in instr[3:0]
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_addi = 4'h5,
        op_li   = 4'h6,
        op_lw   = 4'h7,
        op_sw   = 4'h8,
        op_beq  = 4'h9
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_pass_b = 3'd4
    } alu_op_t;

    // all zero is a nop
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
    } ctrl_t;

    typedef struct packed {
        pc_t   pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        ctrl_t    ctrl;
        pc_t      pc;
        word_t    a;
        word_t    b;
        word_t    store_data;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } de_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
    } em_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
    } mw_t;

    // operand source selects driven by the hazard unit
    localparam logic [1:0] fwd_reg = 2'd0;
    localparam logic [1:0] fwd_mem = 2'd1;
    localparam logic [1:0] fwd_wb  = 2'd2;

    // value written back by the instruction in writeback
    function automatic word_t wb_value(mw_t w);
        return w.mem_read ? w.load_data : w.alu_result;
    endfunction

endpackage

// File: design/cpu_settings.svh
// core-wide sizing macros, included by the package and by any module that needs a width
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and instruction word width
`define CPU_XLEN 16

// architectural registers, r0 reads as zero
`define CPU_NREGS 16

// private instruction memory, in words
`define CPU_IMEM_DEPTH 256

// must cover CPU_IMEM_DEPTH, also the pc width
`define CPU_IMEM_AW 8

`endif
